//--- hw/synth_pkg.sv
// Shared definitions for the synthesizer and audio glue
// Sample types and fixed widths
// Synthesizer mode bytes and info codes
// Info mode values and pixel strobe divider

package synth_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int SAMPLE_W    = 16;
	localparam int WIDE_W      = SAMPLE_W + 1;
	localparam int MIX_W       = 9;
	localparam int MIX_SHIFT   = 7;
	localparam int MODE_W      = 8;
	localparam int INFO_W      = 8;
	localparam int INFO_MODE_W = 2;
	localparam int UART_MODE_W = 8;
	localparam int RGB_W       = 24;

	// Left and right
	localparam int NUM_CHANNELS = 2;

	// Signed audio sample as delivered by the synthesizer
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// One guard bit above the sample for overflow detection
	typedef logic signed [WIDE_W-1:0] wide_sample_t;

	// ========================================================================
	// Synthesizer modes and info codes
	// ========================================================================

	localparam logic [MODE_W-1:0] MODE_SOUNDFONT = 8'hA2;
	localparam logic [MODE_W-1:0] MODE_MT32      = 8'hA1;

	// Soundfont n reports code 1 + n
	localparam logic [INFO_W-1:0] INFO_SF_BASE  = 8'd1;
	// ROM 0, 1 and 2 report 9, 10 and 11
	localparam logic [INFO_W-1:0] INFO_ROM_BASE = 8'd9;
	localparam int                NUM_ROMS      = 3;
	localparam logic [INFO_W-1:0] INFO_UNKNOWN  = 8'd12;

	// Info mode from the OSD menu where 0 means no info
	localparam logic [INFO_MODE_W-1:0] INFO_MODE_REQ  = 2'd1;
	localparam logic [INFO_MODE_W-1:0] INFO_MODE_ON   = 2'd2;
	localparam logic [INFO_MODE_W-1:0] INFO_MODE_AUTO = 2'd3;

	// Synthesizer LCD runs at a third of the pixel rate
	localparam int CE_DIV = 3;

endpackage

//--- hw/synth_gate.sv
// Synthesizer feeder
// Use and mute decisions for the external MIDI synthesizer
// Serial routing between the core UART and the synthesizer
// First audio pipeline stage with per-channel mix level and samples

`timescale 1ns/1ps

module synth_gate
	import synth_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [UART_MODE_W-1:0] uart_mode,
	input  logic                   synth_enable,
	input  logic                   synth_available,
	input  logic [MIX_W-1:0]       audiomix,
	input  sample_t                synth_sample_l,
	input  sample_t                synth_sample_r,
	input  logic                   uart_tx_core,
	input  logic                   uart_rxd,
	input  logic                   midi_rx,
	output logic                   uart_rx_core,
	output logic                   uart_txd,
	output logic                   midi_tx,
	output logic [MIX_W-1:0]       mix_q [NUM_CHANNELS],
	output sample_t                sample_q [NUM_CHANNELS]
);

	logic    synth_use;
	logic    synth_mute;
	logic    route_midi;
	sample_t synth_sample [NUM_CHANNELS];

	// Present and enabled means in use, present but disabled means muted
	assign synth_use  = synth_available & synth_enable;
	assign synth_mute = synth_available & ~synth_enable;

	// No UART function selected, or the synth claims the serial lines
	assign route_midi = (uart_mode == '0) || synth_use;

	// ========================================================================
	// Serial routing
	// ========================================================================

	// Idle line level is high on whichever side is unused
	assign uart_txd     = route_midi ? 1'b1 : uart_tx_core;
	assign uart_rx_core = route_midi ? midi_rx : uart_rxd;
	assign midi_tx      = route_midi ? uart_tx_core : 1'b1;

	// ========================================================================
	// Audio input stage
	// ========================================================================

	// Index 0 is left, index 1 is right
	assign synth_sample[0] = synth_sample_l;
	assign synth_sample[1] = synth_sample_r;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				mix_q[ch]    <= '0;
				sample_q[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				mix_q[ch] <= audiomix;
				// Muted synth contributes silence, the core mix still passes
				sample_q[ch] <= synth_mute ? sample_t'(0) : synth_sample[ch];
			end
		end
	end

endmodule

//--- hw/audio_channel.sv
// One stereo side of the audio mixer
// Adds the shifted core mix level to the synthesizer sample
// Saturates the 17-bit sum back to a signed 16-bit output

`timescale 1ns/1ps

module audio_channel
	import synth_pkg::*;
(
	input  logic             clk_sys,
	input  logic             reset,
	input  logic [MIX_W-1:0] mix,
	input  sample_t          sample,
	output sample_t          audio
);

	localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

	wide_sample_t mix_ext;
	wide_sample_t sample_ext;
	wide_sample_t sum_q;
	logic         overflow;

	// Mix level is always positive, so a zero goes on top
	assign mix_ext    = wide_sample_t'({1'b0, mix, {MIX_SHIFT{1'b0}}});
	assign sample_ext = wide_sample_t'(sample);

	// ========================================================================
	// Sum stage
	// ========================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sum_q <= '0;
		end else begin
			sum_q <= mix_ext + sample_ext;
		end
	end

	// Guard bit and sign bit disagree when the sum left the 16-bit range
	assign overflow = sum_q[WIDE_W-1] ^ sum_q[WIDE_W-2];

	// ========================================================================
	// Clamp stage
	// ========================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio <= '0;
		end else if (overflow) begin
			// Guard bit carries the true sign
			audio <= sum_q[WIDE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
		end else begin
			audio <= sum_q[SAMPLE_W-1:0];
		end
	end

endmodule

//--- hw/synth_info.sv
// Synthesizer info for the OSD
// One-cycle info request on a synthesizer mode change
// Registered info code from mode, ROM and soundfont status

`timescale 1ns/1ps

module synth_info
	import synth_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [INFO_MODE_W-1:0] info_mode,
	input  logic [MODE_W-1:0]      synth_mode,
	input  logic [MODE_W-1:0]      synth_rom,
	input  logic [MODE_W-1:0]      synth_sf,
	input  logic                   synth_newmode,
	output logic                   info_req,
	output logic [INFO_W-1:0]      info
);

	logic              newmode_q;
	logic              newmode_toggle;
	logic [INFO_W-1:0] info_next;

	// ========================================================================
	// Mode change request
	// ========================================================================

	// Synth flips newmode once per mode change
	assign newmode_toggle = newmode_q ^ synth_newmode;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			newmode_q <= 1'b0;
			info_req  <= 1'b0;
		end else begin
			newmode_q <= synth_newmode;
			// Only the request mode pops the info line on the OSD
			info_req  <= newmode_toggle && (info_mode == INFO_MODE_REQ);
		end
	end

	// ========================================================================
	// Info code
	// ========================================================================

	always_comb begin
		info_next = INFO_UNKNOWN;
		if (synth_mode == MODE_SOUNDFONT) begin
			// Eight soundfont slots
			info_next = INFO_SF_BASE + INFO_W'(synth_sf[2:0]);
		end else if (synth_mode == MODE_MT32) begin
			if (synth_rom < MODE_W'(NUM_ROMS)) begin
				info_next = INFO_ROM_BASE + INFO_W'(synth_rom);
			end
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info <= '0;
		end else begin
			info <= info_next;
		end
	end

endmodule

//--- hw/lcd_overlay.sv
// Synthesizer LCD overlay on the core video
// LCD on/off state with the auto-off hold timer
// Pixel overlay of the LCD bit on each colour byte
// Pixel strobe at a third of the core pixel rate

`timescale 1ns/1ps

module lcd_overlay
	import synth_pkg::*;
#(
	parameter int LCD_HOLD_CYCLES = 192_000_000
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [INFO_MODE_W-1:0] info_mode,
	input  logic                   lcd_en,
	input  logic                   lcd_update,
	input  logic                   lcd_pix,
	input  logic                   ce_pix,
	input  logic [RGB_W-1:0]       pixel_rgb,
	output logic [RGB_W-1:0]       video_rgb,
	output logic                   ce_synth
);

	localparam int HOLD_W = $clog2(LCD_HOLD_CYCLES + 1);
	localparam int DIV_W  = $clog2(CE_DIV);

	logic              lcd_on;
	logic              update_q;
	logic [HOLD_W-1:0] hold_cnt;
	logic              overlay;
	logic [DIV_W-1:0]  div_cnt;

	// ========================================================================
	// LCD on/off state
	// ========================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			lcd_on   <= 1'b0;
			update_q <= 1'b0;
			hold_cnt <= '0;
		end else begin
			update_q <= lcd_update;
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - HOLD_W'(1);

			if (info_mode == INFO_MODE_ON) begin
				lcd_on <= 1'b1;
			end else if (info_mode != INFO_MODE_AUTO) begin
				lcd_on <= 1'b0;
			end else begin
				if (hold_cnt == '0)
					lcd_on <= 1'b0;
				// A fresh LCD update wins over the timeout
				if (update_q ^ lcd_update) begin
					lcd_on   <= 1'b1;
					hold_cnt <= HOLD_W'(LCD_HOLD_CYCLES);
				end
			end
		end
	end

	// ========================================================================
	// Pixel overlay
	// ========================================================================

	assign overlay = lcd_on & lcd_en;

	// LCD bit fills the two top bits, the core colour is dimmed below it
	always_comb begin
		for (int i = 0; i < RGB_W / 8; i++) begin
			if (overlay)
				video_rgb[8*i +: 8] = {{2{lcd_pix}}, pixel_rgb[8*i+2 +: 6]};
			else
				video_rgb[8*i +: 8] = pixel_rgb[8*i +: 8];
		end
	end

	// ========================================================================
	// Synth pixel strobe
	// ========================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt  <= '0;
			ce_synth <= 1'b0;
		end else begin
			div_cnt  <= (div_cnt == DIV_W'(CE_DIV - 1)) ? '0 : div_cnt + DIV_W'(1);
			ce_synth <= (div_cnt == '0) && ce_pix;
		end
	end

endmodule

//--- hw/synth_glue_top.sv
// Top level of the synthesizer and audio glue
// Feeder with serial routing, one mixer channel per stereo side
// Info code block and LCD overlay

`timescale 1ns/1ps

module synth_glue_top
	import synth_pkg::*;
#(
	parameter int LCD_HOLD_CYCLES = 192_000_000
) (
	input  logic                   clk_sys,
	input  logic                   reset,

	// Serial lines and synthesizer control
	input  logic [UART_MODE_W-1:0] uart_mode,
	input  logic                   synth_enable,
	input  logic                   synth_available,
	input  logic                   uart_tx_core,
	input  logic                   uart_rxd,
	input  logic                   midi_rx,
	output logic                   uart_rx_core,
	output logic                   uart_txd,
	output logic                   midi_tx,

	// Audio
	input  logic [MIX_W-1:0]       audiomix,
	input  sample_t                synth_sample_l,
	input  sample_t                synth_sample_r,
	output sample_t                audio_l,
	output sample_t                audio_r,

	// Synthesizer status and OSD info
	input  logic [INFO_MODE_W-1:0] info_mode,
	input  logic [MODE_W-1:0]      synth_mode,
	input  logic [MODE_W-1:0]      synth_rom,
	input  logic [MODE_W-1:0]      synth_sf,
	input  logic                   synth_newmode,
	output logic                   info_req,
	output logic [INFO_W-1:0]      info,

	// LCD and video
	input  logic                   lcd_en,
	input  logic                   lcd_update,
	input  logic                   lcd_pix,
	input  logic                   ce_pix,
	input  logic [RGB_W-1:0]       pixel_rgb,
	output logic [RGB_W-1:0]       video_rgb,
	output logic                   ce_synth
);

	logic [MIX_W-1:0] mix_q [NUM_CHANNELS];
	sample_t          sample_q [NUM_CHANNELS];
	sample_t          audio_out [NUM_CHANNELS];

	// ========================================================================
	// Feeder and mixer channels
	// ========================================================================

	synth_gate u_synth_gate (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.uart_mode       (uart_mode),
		.synth_enable    (synth_enable),
		.synth_available (synth_available),
		.audiomix        (audiomix),
		.synth_sample_l  (synth_sample_l),
		.synth_sample_r  (synth_sample_r),
		.uart_tx_core    (uart_tx_core),
		.uart_rxd        (uart_rxd),
		.midi_rx         (midi_rx),
		.uart_rx_core    (uart_rx_core),
		.uart_txd        (uart_txd),
		.midi_tx         (midi_tx),
		.mix_q           (mix_q),
		.sample_q        (sample_q)
	);

	for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
		audio_channel u_audio_channel (
			.clk_sys (clk_sys),
			.reset   (reset),
			.mix     (mix_q[ch]),
			.sample  (sample_q[ch]),
			.audio   (audio_out[ch])
		);
	end

	assign audio_l = audio_out[0];
	assign audio_r = audio_out[1];

	// ========================================================================
	// Info and LCD overlay
	// ========================================================================

	synth_info u_synth_info (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.info_mode     (info_mode),
		.synth_mode    (synth_mode),
		.synth_rom     (synth_rom),
		.synth_sf      (synth_sf),
		.synth_newmode (synth_newmode),
		.info_req      (info_req),
		.info          (info)
	);

	lcd_overlay #(
		.LCD_HOLD_CYCLES (LCD_HOLD_CYCLES)
	) u_lcd_overlay (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.info_mode  (info_mode),
		.lcd_en     (lcd_en),
		.lcd_update (lcd_update),
		.lcd_pix    (lcd_pix),
		.ce_pix     (ce_pix),
		.pixel_rgb  (pixel_rgb),
		.video_rgb  (video_rgb),
		.ce_synth   (ce_synth)
	);

endmodule

//--- testbench/tb_synth_checks.svh
// Reference model and checks for the synthesizer glue testbench
// Expected routing, mixed audio, info code and overlay pixel
// Concurrent assertions over all DUT outputs

`ifndef TB_SYNTH_CHECKS_SVH
`define TB_SYNTH_CHECKS_SVH

// Serial lines belong to the synth when the core UART is off or the synth is in use
function automatic logic midi_routed(input logic [7:0] mode, input logic enable,
	input logic avail);
	return (mode == 8'd0) || (enable && avail);
endfunction

// Core level sits 7 bits up and is always positive
function automatic sample_t mixed_sample(input logic [MIX_W-1:0] mix, input sample_t smp,
	input logic muted);
	int total;
	total = int'(mix) * (2 ** MIX_SHIFT);
	if (!muted)
		total = total + int'(smp);
	if (total > 32767)
		total = 32767;
	else if (total < -32768)
		total = -32768;
	return sample_t'(total);
endfunction

function automatic logic [7:0] info_code(input logic [7:0] mode, input logic [7:0] rom,
	input logic [7:0] sf);
	if (mode == MODE_SOUNDFONT)
		return 8'd1 + {5'd0, sf[2:0]};
	if (mode == MODE_MT32 && rom < 8'd3)
		return INFO_ROM_BASE + rom;
	return INFO_UNKNOWN;
endfunction

// Two copies of the LCD bit on top of the six upper colour bits
function automatic logic [23:0] overlay_pixel(input logic [23:0] rgb, input logic pix);
	logic [23:0] res;
	for (int b = 0; b < 3; b++)
		res[8*b +: 8] = {pix, pix, rgb[8*b+2 +: 6]};
	return res;
endfunction

task automatic log_failure(input string what);
	err_count++;
	$display("Fail at %0t ns: %s", $time, what);
endtask

// ============================================================================
// Serial routing
// ============================================================================

a_uart_txd: assert property (@(posedge clk_sys) disable iff (reset)
	uart_txd == (midi_routed(uart_mode, synth_enable, synth_available) ? 1'b1 : uart_tx_core))
	else log_failure($sformatf("uart_txd is %b", uart_txd));

a_uart_rx_core: assert property (@(posedge clk_sys) disable iff (reset)
	uart_rx_core == (midi_routed(uart_mode, synth_enable, synth_available) ? midi_rx : uart_rxd))
	else log_failure($sformatf("uart_rx_core is %b", uart_rx_core));

a_midi_tx: assert property (@(posedge clk_sys) disable iff (reset)
	midi_tx == (midi_routed(uart_mode, synth_enable, synth_available) ? uart_tx_core : 1'b1))
	else log_failure($sformatf("midi_tx is %b", midi_tx));

// ============================================================================
// Audio three cycles after entry
// ============================================================================

a_audio_l: assert property (@(posedge clk_sys) disable iff (reset)
	cycles_out_of_reset >= 3 |-> audio_l == mixed_sample($past(audiomix, 3),
		$past(synth_sample_l, 3), $past(synth_available && !synth_enable, 3)))
	else log_failure($sformatf("audio_l is %h", audio_l));

a_audio_r: assert property (@(posedge clk_sys) disable iff (reset)
	cycles_out_of_reset >= 3 |-> audio_r == mixed_sample($past(audiomix, 3),
		$past(synth_sample_r, 3), $past(synth_available && !synth_enable, 3)))
	else log_failure($sformatf("audio_r is %h", audio_r));

// ============================================================================
// Info and LCD
// ============================================================================

a_info: assert property (@(posedge clk_sys) disable iff (reset)
	cycles_out_of_reset >= 1 |-> info == info_code($past(synth_mode), $past(synth_rom),
		$past(synth_sf)))
	else log_failure($sformatf("info is %0d", info));

a_info_req: assert property (@(posedge clk_sys) disable iff (reset)
	cycles_out_of_reset >= 2 |-> info_req == (($past(synth_newmode) != $past(synth_newmode, 2))
		&& $past(info_mode) == INFO_MODE_REQ))
	else log_failure($sformatf("info_req is %b", info_req));

a_lcd_forced_on: assert property (@(posedge clk_sys) disable iff (reset)
	(lcd_en && info_mode == INFO_MODE_ON && $past(info_mode) == INFO_MODE_ON)
		|-> video_rgb == overlay_pixel(pixel_rgb, lcd_pix))
	else log_failure($sformatf("overlay missing in mode 2, video_rgb %h", video_rgb));

a_lcd_auto_on: assert property (@(posedge clk_sys) disable iff (reset)
	(lcd_en && info_mode == INFO_MODE_AUTO && upd_age >= 1 && upd_age <= LCD_HOLD - 1)
		|-> video_rgb == overlay_pixel(pixel_rgb, lcd_pix))
	else log_failure($sformatf("overlay off %0d cycles after update", upd_age));

a_lcd_auto_off: assert property (@(posedge clk_sys) disable iff (reset)
	(lcd_en && info_mode == INFO_MODE_AUTO && $past(info_mode) == INFO_MODE_AUTO
		&& upd_age >= LCD_HOLD + 2) |-> video_rgb == pixel_rgb)
	else log_failure($sformatf("overlay still on %0d cycles after update", upd_age));

a_lcd_passthrough: assert property (@(posedge clk_sys) disable iff (reset)
	(!lcd_en || (info_mode == $past(info_mode) && info_mode != INFO_MODE_ON
		&& info_mode != INFO_MODE_AUTO)) |-> video_rgb == pixel_rgb)
	else log_failure($sformatf("video_rgb %h differs from pixel %h", video_rgb, pixel_rgb));

a_ce_rate: assert property (@(posedge clk_sys) disable iff (reset)
	(cycles_out_of_reset >= 4 && $past(ce_pix) && $past(ce_pix, 2) && $past(ce_pix, 3))
		|-> $countones({ce_synth, $past(ce_synth), $past(ce_synth, 2)}) == 1)
	else log_failure("ce_synth not high on one cycle in three");

a_ce_gated: assert property (@(posedge clk_sys) disable iff (reset)
	(cycles_out_of_reset >= 1 && !$past(ce_pix)) |-> !ce_synth)
	else log_failure("ce_synth high without ce_pix");

`endif

//--- testbench/tb_synth_glue.sv
// Testbench for the synthesizer and audio glue
// Clock, reset, watchdog and DUT instance
// Test sequence with one result line per test and closing counts

`timescale 1ns/1ps

module tb_synth_glue
	import synth_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int LCD_HOLD     = 20;
	localparam int FLUSH_CYCLES = 4;
	localparam int MIX_RANDOM   = 40;
	localparam int MUTE_RANDOM  = 20;
	localparam int AGE_MAX      = 255;
	// Cycles per test with the flush
	localparam int RUN_CYCLES   = 68 + (MIX_RANDOM + MUTE_RANDOM + 4) + 10 + 42 + 91;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + RUN_CYCLES + 50) * CLK_PERIOD;

	logic clk_sys = 1'b0;
	logic reset;
	logic [7:0] uart_mode;
	logic synth_enable, synth_available, uart_tx_core, uart_rxd, midi_rx;
	logic uart_rx_core, uart_txd, midi_tx;
	logic [MIX_W-1:0] audiomix;
	sample_t synth_sample_l, synth_sample_r, audio_l, audio_r;
	logic [1:0] info_mode;
	logic [7:0] synth_mode, synth_rom, synth_sf, info;
	logic synth_newmode, info_req;
	logic lcd_en, lcd_update, lcd_pix, ce_pix, ce_synth;
	logic [23:0] pixel_rgb, video_rgb;

	int err_count = 0;
	int err_mark = 0;
	int tests_run = 0;
	int cycles_out_of_reset;
	int upd_age;
	logic upd_prev;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	synth_glue_top #(.LCD_HOLD_CYCLES(LCD_HOLD)) DUT (.*);

	// Age of the last lcd_update toggle seen in auto mode
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cycles_out_of_reset <= 0;
			upd_prev <= 1'b0;
			upd_age <= AGE_MAX;
		end else begin
			if (cycles_out_of_reset < 15)
				cycles_out_of_reset <= cycles_out_of_reset + 1;
			upd_prev <= lcd_update;
			if (info_mode != INFO_MODE_AUTO)
				upd_age <= AGE_MAX;
			else if (lcd_update != upd_prev)
				upd_age <= 1;
			else if (upd_age != AGE_MAX)
				upd_age <= upd_age + 1;
		end
	end

	`include "tb_synth_checks.svh"

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic finish_test(input string name);
		int errs;
		idle_cycles(FLUSH_CYCLES);
		errs = err_count - err_mark;
		err_mark = err_count;
		tests_run++;
		$display("Test %s finished with %0d errors", name, errs);
	endtask

	task automatic drive_audio(input logic [MIX_W-1:0] mix, input sample_t l, input sample_t r);
		@(negedge clk_sys);
		audiomix = mix;
		synth_sample_l = l;
		synth_sample_r = r;
	endtask

	task automatic set_synth_status(input logic [7:0] mode, input logic [7:0] rom,
		input logic [7:0] sf);
		@(negedge clk_sys);
		synth_mode = mode;
		synth_rom = rom;
		synth_sf = sf;
	endtask

	task automatic random_pixels(input int n);
		repeat (n) begin
			@(negedge clk_sys);
			pixel_rgb = 24'($urandom);
			lcd_pix = 1'($urandom_range(1));
		end
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic routing_test();
		for (int i = 0; i < 64; i++) begin
			@(negedge clk_sys);
			uart_mode = i[5] ? 8'($urandom_range(255, 1)) : 8'd0;
			synth_enable = i[4];
			synth_available = i[3];
			{uart_tx_core, uart_rxd, midi_rx} = i[2:0];
		end
		finish_test("routing");
	endtask

	task automatic mixing_test();
		synth_available = 1'b1;
		for (int i = 0; i < MIX_RANDOM + MUTE_RANDOM; i++) begin
			// Second part runs muted
			synth_enable = (i < MIX_RANDOM);
			drive_audio(9'($urandom_range(127)), sample_t'($urandom_range(32767) - 16384),
				sample_t'($urandom_range(32767) - 16384));
		end
		finish_test("mixing");
	endtask

	task automatic saturation_test();
		@(negedge clk_sys);
		synth_enable = 1'b1;
		// Back to back entries keep three in flight
		// Positive sums stay below 2**16 where the guard bit still sees them
		drive_audio(9'd400, 16'sh1000, 16'sh3000);
		drive_audio(9'd0, 16'sh8000, 16'sh8000);
		drive_audio(9'd100, -16'sd50, 16'sh4000);
		drive_audio(9'd300, 16'sd20000, 16'sh8000);
		drive_audio(9'd511, 16'sh8000, 16'sh0000);
		finish_test("saturation");
	endtask

	task automatic info_test();
		for (int sf = 0; sf < 8; sf++)
			set_synth_status(MODE_SOUNDFONT, 8'd0, 8'(sf));
		set_synth_status(MODE_SOUNDFONT, 8'd0, 8'hf5);
		for (int rom = 0; rom < 5; rom++)
			set_synth_status(MODE_MT32, 8'(rom), 8'd3);
		set_synth_status(MODE_MT32, 8'h81, 8'd0);
		set_synth_status(8'h00, 8'd1, 8'd1);
		set_synth_status(8'ha3, 8'd0, 8'd0);
		for (int m = 0; m < 4; m++) begin
			@(negedge clk_sys);
			info_mode = 2'(m);
			@(negedge clk_sys);
			synth_newmode = ~synth_newmode;
			idle_cycles(3);
		end
		@(negedge clk_sys);
		info_mode = 2'd0;
		finish_test("info");
	endtask

	task automatic lcd_test();
		@(negedge clk_sys);
		lcd_en = 1'b1;
		info_mode = INFO_MODE_ON;
		random_pixels(12);
		@(negedge clk_sys);
		info_mode = INFO_MODE_AUTO;
		random_pixels(3);
		@(negedge clk_sys);
		lcd_update = ~lcd_update;
		random_pixels(30);
		@(negedge clk_sys);
		info_mode = 2'd0;
		random_pixels(10);
		@(negedge clk_sys);
		ce_pix = 1'b1;
		idle_cycles(15);
		repeat (12) begin
			@(negedge clk_sys);
			ce_pix = 1'($urandom_range(1));
		end
		finish_test("lcd");
	endtask

	// ========================================================================
	// Sequence and watchdog
	// ========================================================================

	initial begin
		reset = 1'b1;
		uart_mode = 8'd0;
		{synth_enable, synth_available, uart_tx_core, uart_rxd, midi_rx} = '0;
		audiomix = '0;
		synth_sample_l = '0;
		synth_sample_r = '0;
		info_mode = 2'd0;
		{synth_mode, synth_rom, synth_sf} = '0;
		synth_newmode = 1'b0;
		{lcd_en, lcd_update, lcd_pix, ce_pix} = '0;
		pixel_rgb = '0;
		void'($urandom(32'heedd_76a5));
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		routing_test();
		mixing_test();
		saturation_test();
		info_test();
		lcd_test();
		$display("Summary: %0d tests run, %0d errors", tests_run, err_count);
		if (err_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+testbench
hw/synth_pkg.sv
hw/synth_gate.sv
hw/audio_channel.sv
hw/synth_info.sv
hw/lcd_overlay.sv
hw/synth_glue_top.sv
testbench/tb_synth_glue.sv
